//--- Bender.yml
package:
  name: tilemapAddrGen

sources:
  - files:
      - hdl/tilemapPkg.sv
      - hdl/rasterCounter.sv
      - hdl/scrollLayer.sv
      - hdl/tileRamArbiter.sv
      - hdl/tilemapAddrGen.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tilemapTb.sv

//--- dv/tilemapModel.svh
`ifndef TILEMAP_MODEL_SVH
`define TILEMAP_MODEL_SVH

// Expected state of one layer after a clock
typedef struct packed {
	logic [8:0]  scrollX;
	logic [7:0]  scrollY;
	logic [11:0] addr;
	logic [2:0]  row;
	logic [2:0]  rowHi;
	logic [10:0] code;
	logic        hiValid;
	logic [13:0] gfx;
	logic [2:0]  fineX;
} layerModel_t;

// Beam after one clock, {line count, pixel count}
function automatic logic [17:0] nextBeam(input logic [8:0] h, input logic [8:0] v,
		input logic hFall, input logic vFall);
	logic       lineEnd;
	logic [8:0] hN;
	logic [8:0] vN;
	lineEnd = hFall || (h == 9'(tilemapPkg::hTotal - 1));
	hN = lineEnd ? 9'd0 : h + 9'd1;
	vN = v;
	if (lineEnd)
		vN = (v == 9'(tilemapPkg::vTotal - 1)) ? 9'd0 : v + 9'd1;
	// Vsync edge restarts the frame
	if (vFall)
		vN = 9'd0;
	return {vN, hN};
endfunction

// One clock of a layer, scroll and flip rules
function automatic layerModel_t stepLayer(input layerModel_t s, input logic [8:0] h,
		input logic [7:0] v, input logic own, input logic [7:0] rd, input logic flip,
		input tilemapPkg::cpuBus_t cpu, input logic layer);
	layerModel_t n;
	logic [8:0]  x;
	logic [7:0]  y;
	n = s;
	// Wrap by width, then mirror
	x = h + s.scrollX;
	y = v + s.scrollY;
	if (flip) begin
		x = ~x;
		y = ~y;
	end
	// Code complete one clock after the high byte
	if (s.hiValid)
		n.gfx = {s.code, s.rowHi};
	n.hiValid = 1'b0;
	if (own && s.addr[0]) begin
		n.code[10:8] = rd[2:0];
		n.rowHi      = s.row;
		n.hiValid    = 1'b1;
	end else if (own) begin
		n.code[7:0] = rd;
	end
	n.addr  = {y[7:3], x[8:3], x[2]};
	n.row   = y[2:0];
	n.fineX = s.scrollX[2:0];
	if (!cpu.nLatch && cpu.addr[2] == layer) begin
		case (tilemapPkg::regSel_e'(cpu.addr[1:0]))
			tilemapPkg::selScrollXLo: n.scrollX[7:0] = cpu.wdata;
			tilemapPkg::selScrollXHi: n.scrollX[8]   = cpu.wdata[0];
			tilemapPkg::selScrollY:   n.scrollY      = cpu.wdata;
			default: ;
		endcase
	end
	return n;
endfunction

`endif

//--- dv/tilemapTb.sv
module tilemapTb;

	timeunit 1ns;
	timeprecision 1ps;

	`include "tilemapModel.svh"

	localparam int rasterLen    = 3000;
	localparam int scrollRun    = 900;
	localparam int flipLen      = 1000;
	localparam int wrapLen      = 1300;
	localparam int frameWrapLen = 5300;
	localparam int idleLen      = 200;
	// Reset, tests and CPU accesses, plus a fifth
	localparam int runCycles = 12 + rasterLen + 2 * (12 + scrollRun) + flipLen + wrapLen
		+ frameWrapLen + 32 * 2 + idleLen;
	localparam int timeoutLimit = runCycles * 12 / 10;

	logic                clk6M;
	logic                rstN;
	logic                nHsync;
	logic                nVsync;
	logic                flip;
	tilemapPkg::cpuBus_t cpu;
	logic [7:0]          ramRdata;
	logic [12:0]         ramAddr;
	logic [7:0]          ramWdata;
	logic                nRwe;
	logic                nRoe;
	logic [7:0]          cpuRdata;
	logic [13:0]         gfxAddr;
	logic [2:0]          fineXA;
	logic [2:0]          fineXB;

	logic [7:0]  tileRam [8192];
	logic [7:0]  written [16];
	int          seed = 55199;
	int          errorCount = 0;
	int          cycleCount = 0;
	int          lineLen = 64;
	int          frameLines = 40;
	string       testName = "reset";
	// Reference beam and layers
	logic [8:0]  mH;
	logic [8:0]  mV;
	logic        mHsyncD;
	logic        mVsyncD;
	layerModel_t lm [2];

	tilemapAddrGen u_tilemapAddrGen (.*);

	initial begin
		clk6M = 1'b0;
		forever #2 clk6M = ~clk6M;
	end

	// Tile RAM, asynchronous read
	assign ramRdata = tileRam[ramAddr];
	always @(posedge clk6M) begin
		if (!nRwe)
			tileRam[ramAddr] <= ramWdata;
	end

	// Free running syncs, vsync low for the first line of each frame
	initial begin
		nHsync = 1'b1;
		nVsync = 1'b1;
		wait (rstN);
		forever begin
			for (int line = 0; line < frameLines; line++) begin
				@(negedge clk6M);
				nHsync = 1'b0;
				nVsync = (line != 0);
				repeat (8) @(negedge clk6M);
				nHsync = 1'b1;
				repeat (lineLen - 9) @(negedge clk6M);
			end
		end
	end

	task automatic reportMismatch(input string what, input logic [31:0] expV,
			input logic [31:0] actV);
		$display("CHECK FAILED %s %s expected %0h actual %0h", testName, what, expV, actV);
		errorCount++;
	endtask

	// Latch held two clocks, same value written twice
	task automatic scrollWrite(input logic layer, input logic [1:0] sel, input logic [7:0] data);
		cpu.addr   = {11'd0, layer, sel};
		cpu.wdata  = data;
		cpu.nLatch = 1'b0;
		repeat (2) @(negedge clk6M);
		cpu.nLatch = 1'b1;
		@(negedge clk6M);
	endtask

	task automatic cpuAccess(input logic [12:0] addr, input logic [7:0] data, input logic wr);
		cpu.addr  = {1'b0, addr};
		cpu.wdata = data;
		cpu.nRcs  = 1'b0;
		cpu.nWe   = ~wr;
		@(posedge clk6M);
		// Read back the byte written earlier
		if (!wr && cpuRdata !== data)
			reportMismatch("cpuRdata", data, cpuRdata);
		if (!wr && nRoe !== 1'b0)
			reportMismatch("nRoe", 1'b0, nRoe);
		@(negedge clk6M);
		cpu.nRcs = 1'b1;
		cpu.nWe  = 1'b1;
		@(negedge clk6M);
	endtask

	// Compare every clock, then step the reference
	always @(posedge clk6M) begin : compare
		logic [12:0] expAddr;
		logic [7:0]  rdByte;
		logic        hFall;
		logic        vFall;
		// CPU select overrides the layer phase
		expAddr = !cpu.nRcs ? cpu.addr[12:0] : {mH[0], mH[0] ? lm[1].addr : lm[0].addr};
		rdByte  = tileRam[expAddr];
		hFall   = mHsyncD && !nHsync;
		vFall   = mVsyncD && !nVsync;
		if (!rstN) begin
			mH      = '0;
			mV      = '0;
			mHsyncD = 1'b1;
			mVsyncD = 1'b1;
			lm[0]   = '0;
			lm[1]   = '0;
		end else begin
			if (ramAddr !== expAddr)
				reportMismatch("ramAddr", expAddr, ramAddr);
			// Write strobe only for a selected write
			if (nRwe !== !(!cpu.nRcs && !cpu.nWe))
				reportMismatch("nRwe", !(!cpu.nRcs && !cpu.nWe), nRwe);
			if (nRoe !== !(!cpu.nRcs && cpu.nWe))
				reportMismatch("nRoe", !(!cpu.nRcs && cpu.nWe), nRoe);
			if (ramWdata !== cpu.wdata)
				reportMismatch("ramWdata", cpu.wdata, ramWdata);
			if (cpuRdata !== rdByte)
				reportMismatch("cpuRdata", rdByte, cpuRdata);
			if (gfxAddr !== (mH[0] ? lm[1].gfx : lm[0].gfx))
				reportMismatch("gfxAddr", mH[0] ? lm[1].gfx : lm[0].gfx, gfxAddr);
			if (fineXA !== lm[0].fineX)
				reportMismatch("fineXA", lm[0].fineX, fineXA);
			if (fineXB !== lm[1].fineX)
				reportMismatch("fineXB", lm[1].fineX, fineXB);
			lm[0] = stepLayer(lm[0], mH, mV[7:0], !mH[0], rdByte, flip, cpu, 1'b0);
			lm[1] = stepLayer(lm[1], mH, mV[7:0], mH[0], rdByte, flip, cpu, 1'b1);
			{mV, mH} = nextBeam(mH, mV, hFall, vFall);
			mHsyncD = nHsync;
			mVsyncD = nVsync;
		end
	end

	initial begin
		rstN       = 1'b0;
		flip       = 1'b0;
		cpu        = '0;
		cpu.nRcs   = 1'b1;
		cpu.nWe    = 1'b1;
		cpu.nLatch = 1'b1;
		for (int a = 0; a < 8192; a++)
			tileRam[a] = 8'($random(seed)) ^ a[7:0] ^ 8'(a[12:8]);
		repeat (8) @(negedge clk6M);
		rstN = 1'b1;
		repeat (4) @(negedge clk6M);
		testName = "raster";
		repeat (rasterLen) @(negedge clk6M);
		// All codes per layer, code 3 has no register
		testName = "scroll";
		for (int l = 0; l < 2; l++) begin
			for (int r = 0; r < 4; r++)
				scrollWrite(l[0], r[1:0], 8'($random(seed)));
			repeat (scrollRun) @(negedge clk6M);
		end
		testName = "flip";
		flip = 1'b1;
		repeat (flipLen) @(negedge clk6M);
		// Lines longer than hTotal wrap on their own
		testName = "lineWrap";
		lineLen = 420;
		repeat (wrapLen) @(negedge clk6M);
		// Short lines and a long frame so the line count wraps at vTotal
		testName   = "frameWrap";
		lineLen    = 16;
		frameLines = 300;
		repeat (frameWrapLen) @(negedge clk6M);
		testName = "cpuAccess";
		for (int i = 0; i < 16; i++) begin
			written[i] = 8'($random(seed));
			cpuAccess(13'(i * 389 + 5), written[i], 1'b1);
		end
		for (int i = 0; i < 16; i++)
			cpuAccess(13'(i * 389 + 5), written[i], 1'b0);
		repeat (idleLen) @(negedge clk6M);
		$display("Errors: %0d after %0d cycles", errorCount, cycleCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		while (cycleCount < timeoutLimit) begin
			@(posedge clk6M);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", timeoutLimit);
		$display("Errors: %0d after %0d cycles", errorCount, cycleCount);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- hdl/rasterCounter.sv
module rasterCounter #(
	parameter int unsigned hTotal = tilemapPkg::hTotal,
	parameter int unsigned vTotal = tilemapPkg::vTotal
) (
	input  logic               clk6M,
	input  logic               rstN,
	input  logic               nHsync,
	input  logic               nVsync,
	output tilemapPkg::beam_t  beam,
	output logic               frameStart
);

	//////////////////////////////
	// Sync edge detect
	//////////////////////////////

	// Delayed copies of the sync strobes
	logic nHsyncD;
	logic nVsyncD;
	logic hFall;
	logic vFall;

	// Falling edge seen this cycle
	assign hFall = nHsyncD & ~nHsync;
	assign vFall = nVsyncD & ~nVsync;

	//////////////////////////////
	// Pixel and line counters
	//////////////////////////////

	logic [8:0] hCount;
	// Line count needs 9 bits, vTotal exceeds 256
	logic [8:0] vCount;
	logic       hWrap;
	logic       vWrap;
	logic       lineEnd;

	assign hWrap = (hCount == 9'(hTotal - 1));
	assign vWrap = (vCount == 9'(vTotal - 1));
	// Line ends on hsync edge or on natural wrap
	assign lineEnd = hFall | hWrap;

	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			nHsyncD    <= 1'b1;
			nVsyncD    <= 1'b1;
			hCount     <= '0;
			vCount     <= '0;
			frameStart <= 1'b0;
		end else begin
			nHsyncD    <= nHsync;
			nVsyncD    <= nVsync;
			// Pulse lines up with vPos clearing
			frameStart <= vFall;

			if (lineEnd) begin
				hCount <= '0;
			end else begin
				hCount <= hCount + 9'd1;
			end

			// Vsync edge wins over line stepping
			if (vFall) begin
				vCount <= '0;
			end else if (lineEnd) begin
				vCount <= vWrap ? 9'd0 : vCount + 9'd1;
			end
		end
	end

	// Visible part of the line count
	assign beam.hPos = hCount;
	assign beam.vPos = vCount[7:0];

endmodule

//--- hdl/scrollLayer.sv
module scrollLayer #(
	parameter bit autoscroll = 1'b0
) (
	input  logic                  clk6M,
	input  logic                  rstN,
	input  logic                  flip,
	input  logic                  nLatch,
	input  logic                  frameStart,
	input  tilemapPkg::regSel_e   regSel,
	input  logic [7:0]            wdata,
	input  tilemapPkg::beam_t     beam,
	input  logic                  phaseOwn,
	input  logic [7:0]            ramRdata,
	output tilemapPkg::layerOut_t out
);

	//////////////////////////////
	// Scroll registers
	//////////////////////////////

	tilemapPkg::scroll_t scroll;

	// Latch is a level, rewritten every cycle it stays low
	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			scroll <= '0;
		end else if (!nLatch) begin
			case (regSel)
				tilemapPkg::selScrollXLo: scroll.scrollX[7:0] <= wdata;
				tilemapPkg::selScrollXHi: scroll.scrollX[8] <= wdata[0];
				tilemapPkg::selScrollY:   scroll.scrollY <= wdata;
				// Code 3 has no register
				default: ;
			endcase
		end else if (autoscroll && frameStart) begin
			// One pixel per frame
			scroll.scrollX <= scroll.scrollX + 9'd1;
		end
	end

	//////////////////////////////
	// Scrolled coordinates
	//////////////////////////////

	logic [8:0] sumX;
	logic [7:0] sumY;
	logic [8:0] effX;
	logic [7:0] effY;

	// Modulo 512 and 256 by width
	assign sumX = beam.hPos + scroll.scrollX;
	assign sumY = beam.vPos + scroll.scrollY;

	// Flip mirrors the whole map
	assign effX = flip ? ~sumX : sumX;
	assign effY = flip ? ~sumY : sumY;

	//////////////////////////////
	// Tile fetch pipeline
	//////////////////////////////

	logic [11:0] ramAddrQ;
	// Tile row travelling with the address
	logic [2:0]  rowQ;
	logic [2:0]  rowHi;
	logic [7:0]  codeLo;
	logic [2:0]  codeHi;
	logic        hiValid;
	logic [13:0] gfxAddrQ;
	logic [2:0]  fineXQ;

	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			ramAddrQ <= '0;
			rowQ     <= '0;
			rowHi    <= '0;
			codeLo   <= '0;
			codeHi   <= '0;
			hiValid  <= 1'b0;
			gfxAddrQ <= '0;
			fineXQ   <= '0;
		end else begin
			// Row, column, then byte select from x bit 2
			ramAddrQ <= {effY[7:3], effX[8:3], effX[2]};
			rowQ     <= effY[2:0];
			fineXQ   <= scroll.scrollX[2:0];
			hiValid  <= 1'b0;

			// Capture only on our half of the RAM
			if (phaseOwn) begin
				if (ramAddrQ[0]) begin
					// High byte gives code bits 10 to 8
					codeHi  <= ramRdata[2:0];
					rowHi   <= rowQ;
					hiValid <= 1'b1;
				end else begin
					codeLo <= ramRdata;
				end
			end

			// Full code known one cycle after high byte
			if (hiValid) begin
				gfxAddrQ <= {codeHi, codeLo, rowHi};
			end
		end
	end

	assign out.ramAddr = ramAddrQ;
	assign out.gfxAddr = gfxAddrQ;
	assign out.fineX   = fineXQ;

endmodule

//--- hdl/tileRamArbiter.sv
module tileRamArbiter (
	input  tilemapPkg::cpuBus_t   cpu,
	input  tilemapPkg::beam_t     beam,
	input  tilemapPkg::layerOut_t layerA,
	input  tilemapPkg::layerOut_t layerB,
	input  logic [7:0]            ramRdata,
	output logic [12:0]           ramAddr,
	output logic [7:0]            ramWdata,
	output logic                  nRwe,
	output logic                  nRoe,
	output logic [7:0]            cpuRdata,
	output logic [13:0]           gfxAddr,
	output logic                  ownA,
	output logic                  ownB,
	output logic [2:0]            fineXA,
	output logic [2:0]            fineXB
);

	//////////////////////////////
	// Phase ownership
	//////////////////////////////

	// Even pixels to A, odd pixels to B
	assign ownB = beam.hPos[0];
	assign ownA = ~beam.hPos[0];

	//////////////////////////////
	// Tile RAM address
	//////////////////////////////

	logic        cpuSel;
	logic [11:0] layerAddr;

	assign cpuSel = ~cpu.nRcs;
	assign layerAddr = ownB ? layerB.ramAddr : layerA.ramAddr;

	always_comb begin
		if (cpuSel) begin
			// CPU takes the RAM, layer fetches see its data
			ramAddr = cpu.addr[12:0];
		end else begin
			// Layer bit on top splits the RAM in halves
			ramAddr = {ownB, layerAddr};
		end
	end

	//////////////////////////////
	// RAM strobes and data
	//////////////////////////////

	// Write only for a selected CPU write
	assign nRwe = cpu.nRcs | cpu.nWe;
	// Read enable for a selected CPU read
	assign nRoe = cpu.nRcs | ~cpu.nWe;

	// Separate buses in place of the shared data pins
	assign ramWdata = cpu.wdata;
	assign cpuRdata = ramRdata;

	//////////////////////////////
	// Graphics side
	//////////////////////////////

	// ROM address follows the phase owner
	assign gfxAddr = ownB ? layerB.gfxAddr : layerA.gfxAddr;

	// Fine scroll per layer to the pixel shifter
	assign fineXA = layerA.fineX;
	assign fineXB = layerB.fineX;

endmodule

//--- hdl/tilemapAddrGen.sv
module tilemapAddrGen #(
	parameter int unsigned hTotal      = tilemapPkg::hTotal,
	parameter int unsigned vTotal      = tilemapPkg::vTotal,
	parameter bit          autoscrollA = 1'b0,
	parameter bit          autoscrollB = 1'b0
) (
	input  logic                clk6M,
	input  logic                rstN,
	input  logic                nHsync,
	input  logic                nVsync,
	input  logic                flip,
	input  tilemapPkg::cpuBus_t cpu,
	input  logic [7:0]          ramRdata,
	output logic [12:0]         ramAddr,
	output logic [7:0]          ramWdata,
	output logic                nRwe,
	output logic                nRoe,
	output logic [7:0]          cpuRdata,
	output logic [13:0]         gfxAddr,
	output logic [2:0]          fineXA,
	output logic [2:0]          fineXB
);

	tilemapPkg::beam_t     beam;
	tilemapPkg::layerOut_t outA;
	tilemapPkg::layerOut_t outB;
	tilemapPkg::regSel_e   regSel;
	logic                  frameStart;
	logic                  ownA;
	logic                  ownB;
	logic                  nLatchA;
	logic                  nLatchB;

	//////////////////////////////
	// Scroll latch decode
	//////////////////////////////

	// addr[2] picks the layer
	assign nLatchA = cpu.nLatch | cpu.addr[2];
	assign nLatchB = cpu.nLatch | ~cpu.addr[2];
	assign regSel  = tilemapPkg::regSel_e'(cpu.addr[1:0]);

	//////////////////////////////
	// Instances
	//////////////////////////////

	rasterCounter #(
		.hTotal(hTotal),
		.vTotal(vTotal)
	) raster (
		.clk6M      (clk6M),
		.rstN       (rstN),
		.nHsync     (nHsync),
		.nVsync     (nVsync),
		.beam       (beam),
		.frameStart (frameStart)
	);

	scrollLayer #(
		.autoscroll(autoscrollA)
	) layerA (
		.clk6M      (clk6M),
		.rstN       (rstN),
		.flip       (flip),
		.nLatch     (nLatchA),
		.frameStart (frameStart),
		.regSel     (regSel),
		.wdata      (cpu.wdata),
		.beam       (beam),
		.phaseOwn   (ownA),
		.ramRdata   (ramRdata),
		.out        (outA)
	);

	scrollLayer #(
		.autoscroll(autoscrollB)
	) layerB (
		.clk6M      (clk6M),
		.rstN       (rstN),
		.flip       (flip),
		.nLatch     (nLatchB),
		.frameStart (frameStart),
		.regSel     (regSel),
		.wdata      (cpu.wdata),
		.beam       (beam),
		.phaseOwn   (ownB),
		.ramRdata   (ramRdata),
		.out        (outB)
	);

	// Shared tile RAM and ROM address mux
	tileRamArbiter arbiter (
		.cpu      (cpu),
		.beam     (beam),
		.layerA   (outA),
		.layerB   (outB),
		.ramRdata (ramRdata),
		.ramAddr  (ramAddr),
		.ramWdata (ramWdata),
		.nRwe     (nRwe),
		.nRoe     (nRoe),
		.cpuRdata (cpuRdata),
		.gfxAddr  (gfxAddr),
		.ownA     (ownA),
		.ownB     (ownB),
		.fineXA   (fineXA),
		.fineXB   (fineXB)
	);

endmodule

//--- hdl/tilemapPkg.sv
package tilemapPkg;

	//////////////////////////////
	// Raster geometry
	//////////////////////////////

	// Pixel clocks per line
	parameter int unsigned hTotal = 384;
	// Lines per frame
	parameter int unsigned vTotal = 264;

	//////////////////////////////
	// Bus and pipeline types
	//////////////////////////////

	// CPU side of the chip, strobes active low
	typedef struct packed {
		logic [13:0] addr;
		logic [7:0]  wdata;
		// Tile RAM select
		logic        nRcs;
		logic        nWe;
		// Scroll register latch
		logic        nLatch;
	} cpuBus_t;

	// Beam position
	typedef struct packed {
		logic [8:0] hPos;
		logic [7:0] vPos;
	} beam_t;

	typedef struct packed {
		logic [8:0] scrollX;
		logic [7:0] scrollY;
	} scroll_t;

	// Per layer result handed to the arbiter
	typedef struct packed {
		logic [11:0] ramAddr;
		logic [13:0] gfxAddr;
		logic [2:0]  fineX;
	} layerOut_t;

	// Scroll register select, CPU addr[1:0], code 3 unused
	typedef enum logic [1:0] {
		selScrollXLo = 2'd0,
		selScrollXHi = 2'd1,
		selScrollY   = 2'd2
	} regSel_e;

endpackage

//--- tilemapAddrGen.f
+incdir+dv
hdl/tilemapPkg.sv
hdl/rasterCounter.sv
hdl/scrollLayer.sv
hdl/tileRamArbiter.sv
hdl/tilemapAddrGen.sv
dv/tilemapTb.sv
